// File: hdl/lc3b_pkg.sv
`default_nettype none

package lc3b_pkg;

    typedef logic [15:0] lc3b_word;
    typedef logic [2:0] lc3b_reg;

    // architectural register file size
    localparam int reg_count = 8;

    // operand forwarding selects
    localparam logic [1:0] fwd_rf = 2'd0;
    localparam logic [1:0] fwd_mem = 2'd1;
    localparam logic [1:0] fwd_wb = 2'd2;

    // other encodings decode as no-operation
    typedef enum logic [3:0] {
        op_br = 4'b0000,
        op_add = 4'b0001,
        op_and = 4'b0101,
        op_ldr = 4'b0110,
        op_str = 4'b0111,
        op_not = 4'b1001,
        op_jmp = 4'b1100,
        op_lea = 4'b1110
    } lc3b_opcode;

    typedef enum logic [1:0] {
        alu_add,
        alu_and,
        alu_not,
        alu_pass
    } lc3b_aluop;

    // all-zero value is a bubble
    typedef struct packed {
        lc3b_aluop aluop;
        logic b_is_imm;
        logic a_is_pc;
        logic mem_read;
        logic mem_write;
        logic load_regfile;
        logic load_cc;
        logic branch;
        logic jump;
        lc3b_reg dest;
        logic [2:0] nzp;
    } lc3b_ctrl;

endpackage

`default_nettype wire

// File: hdl/lc3b_ifaces.sv
`timescale 1ns/1ps
`default_nettype none

// decode to execute bundle
interface dx_if import lc3b_pkg::*; ();
    lc3b_ctrl ctrl;
    lc3b_word pc;
    lc3b_word a_val;
    lc3b_word b_val;
    lc3b_reg src_a;
    lc3b_reg src_b;
    lc3b_word imm;

    modport src
    (
        output ctrl, pc, a_val, b_val, src_a, src_b, imm
    );

    modport dst
    (
        input ctrl, pc, a_val, b_val, src_a, src_b, imm
    );
endinterface

// execute to memory bundle
interface xm_if import lc3b_pkg::*; ();
    lc3b_ctrl ctrl;
    // also the data memory address
    lc3b_word alu_out;
    lc3b_word store_data;

    modport src
    (
        output ctrl, alu_out, store_data
    );

    modport dst
    (
        input ctrl, alu_out, store_data
    );
endinterface

`default_nettype wire

// File: hdl/fetch_stage.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_stage import lc3b_pkg::*;
#(
    parameter lc3b_word reset_pc = 16'h0000
)
(
    input logic clk,
    input logic reset,
    input logic stall,
    input logic load_stall,
    input logic redirect,
    input lc3b_word redirect_pc,
    input lc3b_word i_rdata,
    input logic i_resp,
    output lc3b_word i_addr,
    output logic i_read,
    output lc3b_word ir,
    output lc3b_word if_pc,
    output logic if_valid
);

    lc3b_word pc;
    lc3b_word pc_plus2;
    logic fetch_on;
    logic pend_valid;
    lc3b_word pend_ir;
    logic advance;
    logic got;
    logic have_word;

    assign advance = !stall && !load_stall;
    assign got = i_read && i_resp;
    // word parked while the pipeline was frozen
    assign have_word = pend_valid || got;
    assign pc_plus2 = pc + 16'd2;

    assign i_addr = pc;
    assign i_read = fetch_on && !pend_valid && !redirect;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            pc <= reset_pc;
            fetch_on <= 1'b0;
            pend_valid <= 1'b0;
            if_valid <= 1'b0;
        end
        else
        begin
            fetch_on <= 1'b1;
            if (redirect)
            begin
                pc <= redirect_pc;
                pend_valid <= 1'b0;
                if_valid <= 1'b0;
            end
            else if (advance)
            begin
                // no word yet means a bubble into decode
                if_valid <= have_word;
                pend_valid <= 1'b0;
                if (have_word)
                    pc <= pc_plus2;
            end
            else if (got)
                pend_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (advance && have_word)
        begin
            ir <= pend_valid ? pend_ir : i_rdata;
            if_pc <= pc_plus2;
        end
        if (!advance && got)
            pend_ir <= i_rdata;
    end

endmodule

`default_nettype wire

// File: hdl/decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage import lc3b_pkg::*;
(
    input logic clk,
    input logic reset,
    input lc3b_word ir,
    input lc3b_word if_pc,
    input logic if_valid,
    input logic stall,
    input logic load_stall,
    input logic redirect,
    input lc3b_word wb_data,
    input lc3b_reg wb_dest,
    input logic wb_load,
    dx_if.src dx
);

    lc3b_word regs [reg_count];
    lc3b_opcode opcode;
    lc3b_ctrl ctrl_d;
    lc3b_word imm_d;
    lc3b_word imm5;
    lc3b_word off6;
    lc3b_word off9;
    lc3b_reg src_a_d;
    lc3b_reg src_b_d;
    lc3b_reg rd_a;
    lc3b_reg rd_b;
    lc3b_word rd_a_val;
    lc3b_word rd_b_val;

    assign opcode = lc3b_opcode'(ir[15:12]);
    assign imm5 = {{11{ir[4]}}, ir[4:0]};
    // word offsets, scaled to bytes
    assign off6 = {{9{ir[5]}}, ir[5:0], 1'b0};
    assign off9 = {{6{ir[8]}}, ir[8:0], 1'b0};

    assign src_a_d = ir[8:6];
    // STR reads its data register from the dest field
    assign src_b_d = (opcode == op_str) ? ir[11:9] : ir[2:0];

    always_comb
    begin
        ctrl_d = '0;
        imm_d = imm5;
        ctrl_d.dest = ir[11:9];
        ctrl_d.nzp = ir[11:9];
        if (if_valid)
        begin
            case (opcode)
                op_add, op_and:
                begin
                    ctrl_d.aluop = (opcode == op_add) ? alu_add : alu_and;
                    ctrl_d.b_is_imm = ir[5];
                    ctrl_d.load_regfile = 1'b1;
                    ctrl_d.load_cc = 1'b1;
                end
                op_not:
                begin
                    ctrl_d.aluop = alu_not;
                    ctrl_d.load_regfile = 1'b1;
                    ctrl_d.load_cc = 1'b1;
                end
                op_lea:
                begin
                    // no condition code update
                    ctrl_d.a_is_pc = 1'b1;
                    ctrl_d.b_is_imm = 1'b1;
                    ctrl_d.load_regfile = 1'b1;
                    imm_d = off9;
                end
                op_ldr:
                begin
                    ctrl_d.b_is_imm = 1'b1;
                    ctrl_d.mem_read = 1'b1;
                    ctrl_d.load_regfile = 1'b1;
                    ctrl_d.load_cc = 1'b1;
                    imm_d = off6;
                end
                op_str:
                begin
                    ctrl_d.b_is_imm = 1'b1;
                    ctrl_d.mem_write = 1'b1;
                    imm_d = off6;
                end
                op_br:
                begin
                    ctrl_d.a_is_pc = 1'b1;
                    ctrl_d.b_is_imm = 1'b1;
                    ctrl_d.branch = 1'b1;
                    imm_d = off9;
                end
                op_jmp:
                begin
                    ctrl_d.aluop = alu_pass;
                    ctrl_d.jump = 1'b1;
                end
                default:
                begin
                end
            endcase
        end
    end

    // refresh the held execute operands during the load-use bubble
    assign rd_a = load_stall ? dx.src_a : src_a_d;
    assign rd_b = load_stall ? dx.src_b : src_b_d;
    assign rd_a_val = (wb_load && wb_dest == rd_a) ? wb_data : regs[rd_a];
    assign rd_b_val = (wb_load && wb_dest == rd_b) ? wb_data : regs[rd_b];

    always_ff @(posedge clk)
    begin
        if (wb_load)
            regs[wb_dest] <= wb_data;
    end

    always_ff @(posedge clk)
    begin
        if (reset || redirect)
            dx.ctrl <= '0;
        else if (!stall && !load_stall)
            dx.ctrl <= ctrl_d;
    end

    always_ff @(posedge clk)
    begin
        if (!stall && !load_stall)
        begin
            dx.pc <= if_pc;
            dx.imm <= imm_d;
            dx.src_a <= src_a_d;
            dx.src_b <= src_b_d;
            dx.a_val <= rd_a_val;
            dx.b_val <= rd_b_val;
        end
        else if (!stall)
        begin
            dx.a_val <= rd_a_val;
            dx.b_val <= rd_b_val;
        end
    end

endmodule

`default_nettype wire

// File: hdl/execute_stage.sv
`timescale 1ns/1ps
`default_nettype none

module execute_stage import lc3b_pkg::*;
(
    input logic clk,
    input logic reset,
    dx_if.dst dx,
    input logic [1:0] fwd_a_sel,
    input logic [1:0] fwd_b_sel,
    input lc3b_word mem_fwd,
    input lc3b_word wb_data,
    input logic stall,
    input logic load_stall,
    input logic redirect,
    xm_if.src xm
);

    lc3b_word a_fwd;
    lc3b_word b_fwd;
    lc3b_word alu_a;
    lc3b_word alu_b;
    lc3b_word alu_out;

    function automatic lc3b_word fwd_mux(input logic [1:0] sel, input lc3b_word rf_val);
        case (sel)
            fwd_mem: return mem_fwd;
            fwd_wb: return wb_data;
            default: return rf_val;
        endcase
    endfunction

    assign a_fwd = fwd_mux(fwd_a_sel, dx.a_val);
    assign b_fwd = fwd_mux(fwd_b_sel, dx.b_val);

    // PC for LEA and BR targets, immediate for offsets
    assign alu_a = dx.ctrl.a_is_pc ? dx.pc : a_fwd;
    assign alu_b = dx.ctrl.b_is_imm ? dx.imm : b_fwd;

    always_comb
    begin
        case (dx.ctrl.aluop)
            alu_add: alu_out = alu_a + alu_b;
            alu_and: alu_out = alu_a & alu_b;
            alu_not: alu_out = ~alu_a;
            default: alu_out = alu_a;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset || redirect)
            xm.ctrl <= '0;
        else if (!stall)
            xm.ctrl <= load_stall ? lc3b_ctrl'('0) : dx.ctrl;
    end

    always_ff @(posedge clk)
    begin
        if (!stall)
        begin
            xm.alu_out <= alu_out;
            xm.store_data <= b_fwd;
        end
    end

endmodule

`default_nettype wire

// File: hdl/mem_wb_stage.sv
`timescale 1ns/1ps
`default_nettype none

module mem_wb_stage import lc3b_pkg::*;
(
    input logic clk,
    input logic reset,
    xm_if.dst xm,
    input logic stall,
    input lc3b_word d_rdata,
    input logic d_resp,
    output lc3b_word d_addr,
    output logic d_read,
    output logic d_write,
    output lc3b_word d_wdata,
    output lc3b_word mem_fwd,
    output lc3b_word wb_data,
    output lc3b_reg wb_dest,
    output logic wb_load,
    output logic redirect,
    output lc3b_word redirect_pc,
    output lc3b_reg mem_dest,
    output logic mem_load,
    output logic mem_is_read
);

    logic d_done;
    lc3b_word d_hold;
    lc3b_word mem_val;
    lc3b_ctrl wb_ctrl;
    lc3b_word wb_val;
    logic [2:0] cc;
    logic [2:0] gen_cc;

    // request ends once answered, even if the stage is still frozen
    assign d_addr = xm.alu_out;
    assign d_wdata = xm.store_data;
    assign d_read = xm.ctrl.mem_read && !d_done && !redirect;
    assign d_write = xm.ctrl.mem_write && !d_done && !redirect;

    assign mem_val = !xm.ctrl.mem_read ? xm.alu_out : (d_done ? d_hold : d_rdata);
    assign mem_fwd = xm.alu_out;
    assign mem_dest = xm.ctrl.dest;
    assign mem_load = xm.ctrl.load_regfile;
    assign mem_is_read = xm.ctrl.mem_read;

    always_ff @(posedge clk)
    begin
        if (reset)
            d_done <= 1'b0;
        else if (redirect || !stall)
            d_done <= 1'b0;
        else if (d_resp && (d_read || d_write))
            d_done <= 1'b1;
    end

    always_ff @(posedge clk)
    begin
        if (d_resp)
            d_hold <= d_rdata;
        if (!stall)
            wb_val <= mem_val;
    end

    // a redirecting branch leaves writeback as a bubble
    always_ff @(posedge clk)
    begin
        if (reset || redirect)
            wb_ctrl <= '0;
        else if (!stall)
            wb_ctrl <= xm.ctrl;
    end

    assign wb_data = wb_val;
    assign wb_dest = wb_ctrl.dest;
    assign wb_load = wb_ctrl.load_regfile;

    assign gen_cc = wb_val[15] ? 3'b100 : ((wb_val == 16'h0000) ? 3'b010 : 3'b001);

    always_ff @(posedge clk)
    begin
        if (reset)
            cc <= 3'b010;
        else if (wb_ctrl.load_cc)
            cc <= gen_cc;
    end

    // target comes through the ALU for both BR and JMP
    assign redirect = wb_ctrl.jump || (wb_ctrl.branch && (wb_ctrl.nzp & cc) != 3'b000);
    assign redirect_pc = wb_val;

endmodule

`default_nettype wire

// File: hdl/hazard_unit.sv
`timescale 1ns/1ps
`default_nettype none

module hazard_unit import lc3b_pkg::*;
(
    input logic clk,
    input logic reset,
    dx_if.dst dx,
    input lc3b_reg mem_dest,
    input logic mem_load,
    input logic mem_is_read,
    input lc3b_reg wb_dest,
    input logic wb_load,
    input logic i_read,
    input logic i_resp,
    input logic d_read,
    input logic d_write,
    input logic d_resp,
    output logic [1:0] fwd_a_sel,
    output logic [1:0] fwd_b_sel,
    output logic load_stall,
    output logic stall
);

    logic load_hit;
    logic bubble_done;

    // memory stage wins, loads there cannot forward yet
    function automatic logic [1:0] fwd_pick(input lc3b_reg src);
        if (mem_load && !mem_is_read && mem_dest == src)
            return fwd_mem;
        else if (wb_load && wb_dest == src)
            return fwd_wb;
        else
            return fwd_rf;
    endfunction

    assign fwd_a_sel = fwd_pick(dx.src_a);
    assign fwd_b_sel = fwd_pick(dx.src_b);

    assign load_hit = mem_is_read && mem_load
        && (mem_dest == dx.src_a || mem_dest == dx.src_b);
    assign load_stall = load_hit && !bubble_done;

    // any request still waiting for its answer
    assign stall = (i_read && !i_resp) || ((d_read || d_write) && !d_resp);

    always_ff @(posedge clk)
    begin
        if (reset)
            bubble_done <= 1'b0;
        else if (!stall)
            bubble_done <= load_stall;
    end

endmodule

`default_nettype wire

// File: hdl/lc3b_pipeline.sv
`timescale 1ns/1ps
`default_nettype none

module lc3b_pipeline import lc3b_pkg::*;
#(
    parameter lc3b_word reset_pc = 16'h0000
)
(
    input logic clk,
    input logic reset,
    output lc3b_word i_addr,
    output logic i_read,
    input lc3b_word i_rdata,
    input logic i_resp,
    output lc3b_word d_addr,
    output logic d_read,
    output logic d_write,
    output lc3b_word d_wdata,
    input lc3b_word d_rdata,
    input logic d_resp
);

    lc3b_word ir;
    lc3b_word if_pc;
    logic if_valid;
    logic stall;
    logic load_stall;
    logic redirect;
    lc3b_word redirect_pc;
    lc3b_word mem_fwd;
    lc3b_word wb_data;
    lc3b_reg wb_dest;
    logic wb_load;
    lc3b_reg mem_dest;
    logic mem_load;
    logic mem_is_read;
    logic [1:0] fwd_a_sel;
    logic [1:0] fwd_b_sel;

    dx_if dx();
    xm_if xm();

    fetch_stage #(.reset_pc(reset_pc)) fetch0
    (
        .clk, .reset, .stall, .load_stall, .redirect, .redirect_pc,
        .i_rdata, .i_resp, .i_addr, .i_read, .ir, .if_pc, .if_valid
    );

    decode_stage decode0
    (
        .clk, .reset, .ir, .if_pc, .if_valid, .stall, .load_stall, .redirect,
        .wb_data, .wb_dest, .wb_load, .dx(dx)
    );

    execute_stage execute0
    (
        .clk, .reset, .dx(dx), .fwd_a_sel, .fwd_b_sel, .mem_fwd, .wb_data,
        .stall, .load_stall, .redirect, .xm(xm)
    );

    mem_wb_stage mem_wb0
    (
        .clk, .reset, .xm(xm), .stall, .d_rdata, .d_resp,
        .d_addr, .d_read, .d_write, .d_wdata, .mem_fwd,
        .wb_data, .wb_dest, .wb_load, .redirect, .redirect_pc,
        .mem_dest, .mem_load, .mem_is_read
    );

    hazard_unit hazard0
    (
        .clk, .reset, .dx(dx), .mem_dest, .mem_load, .mem_is_read,
        .wb_dest, .wb_load, .i_read, .i_resp, .d_read, .d_write, .d_resp,
        .fwd_a_sel, .fwd_b_sel, .load_stall, .stall
    );

endmodule

`default_nettype wire

// File: bench/lc3b_pipeline_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module lc3b_pipeline_assertions import lc3b_pkg::*;
(
    input logic clk,
    input logic reset,
    input lc3b_word i_addr,
    input logic i_read,
    input logic i_resp,
    input lc3b_word d_addr,
    input logic d_read,
    input logic d_write,
    input lc3b_word d_wdata,
    input logic d_resp,
    input logic load_stall,
    input logic stall,
    input logic redirect
);

    int failures = 0;

    // pending requests hold still until answered
    fetch_held: assert property (@(posedge clk) disable iff (reset)
        i_read && !i_resp |=> i_read && $stable(i_addr))
    else
    begin
        failures++;
        $error("instruction request changed before its response");
    end

    data_held: assert property (@(posedge clk) disable iff (reset)
        (d_read || d_write) && !d_resp |=> $stable({d_read, d_write, d_addr, d_wdata}))
    else
    begin
        failures++;
        $error("data request changed before its response");
    end

    // one bubble per load-use pair
    one_bubble: assert property (@(posedge clk) disable iff (reset)
        load_stall && !stall |=> !load_stall)
    else
    begin
        failures++;
        $error("load-use interlock held for a second cycle");
    end

    // flushed stages keep the data port quiet until the target can reach memory
    no_flushed_write: assert property (@(posedge clk) disable iff (reset)
        redirect |-> !d_write ##1 !d_write ##1 !d_write ##1 !d_write)
    else
    begin
        failures++;
        $error("data write raised by an instruction behind a taken branch");
    end

endmodule

bind lc3b_pipeline lc3b_pipeline_assertions checks0
(
    .clk, .reset, .i_addr, .i_read, .i_resp, .d_addr, .d_read, .d_write,
    .d_wdata, .d_resp, .load_stall, .stall, .redirect
);

`default_nettype wire

// File: bench/lc3b_pipeline_tb.sv
`timescale 1ns/1ps
`default_nettype none

module lc3b_pipeline_tb import lc3b_pkg::*;
();

    localparam lc3b_word start_pc = 16'h0000;
    localparam int cycles_per_instr = 60;
    localparam int unsigned rng_seed = 32'h46a32416;

    logic clk;
    logic reset;
    lc3b_word i_addr;
    logic i_read;
    lc3b_word i_rdata;
    logic i_resp;
    lc3b_word d_addr;
    logic d_read;
    logic d_write;
    lc3b_word d_wdata;
    lc3b_word d_rdata;
    logic d_resp;

    lc3b_word imem [256];
    lc3b_word dmem [256];
    lc3b_word exp_addr [$];
    lc3b_word exp_data [$];
    lc3b_word seen_addr [$];
    lc3b_word seen_data [$];
    int n_instr = 0;
    int n_checked = 0;
    int errors = 0;
    int cycles = 0;
    int limit;
    int i_wait;
    int d_wait;

    lc3b_pipeline #(.reset_pc(start_pc)) dut0
    (
        .clk, .reset, .i_addr, .i_read, .i_rdata, .i_resp,
        .d_addr, .d_read, .d_write, .d_wdata, .d_rdata, .d_resp
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    always @(posedge clk)
        cycles <= cycles + 1;

    function automatic lc3b_word reg_form(input lc3b_opcode op, input int d, input int s,
                                          input int t);
        return {op, 3'(d), 3'(s), 3'b000, 3'(t)};
    endfunction

    function automatic lc3b_word imm_form(input lc3b_opcode op, input int d, input int s,
                                          input int imm);
        return {op, 3'(d), 3'(s), 1'b1, 5'(imm)};
    endfunction

    // LDR, STR, NOT and JMP all share the base-register layout
    function automatic lc3b_word base_form(input lc3b_opcode op, input int r, input int base,
                                           input int off);
        return {op, 3'(r), 3'(base), 6'(off)};
    endfunction

    function automatic lc3b_word pc_form(input lc3b_opcode op, input int r, input int off);
        return {op, 3'(r), 9'(off)};
    endfunction

    task automatic put_instr(input lc3b_word w);
        imem[start_pc[8:1] + n_instr] = w;
        n_instr++;
    endtask

    task automatic build_program();
        int i;
        int d;
        int prev;
        int prev2;
        int v;
        lc3b_word w;
        // never-taken branches, so runaway fetches act as no-ops
        for (i = 0; i < 256; i++)
        begin
            imem[i] = {7'b0000000, 9'(i)};
            dmem[i] = 16'(i * 16'h9e37) ^ 16'h5a3c;
        end
        for (i = 0; i < reg_count; i++)
            put_instr(imm_form(op_and, i, i, 0));
        put_instr(imm_form(op_add, 6, 6, 12));
        put_instr(reg_form(op_add, 6, 6, 6));
        // dependent ALU chains over r0..r5
        prev = 0;
        prev2 = 1;
        for (i = 0; i < 24; i++)
        begin
            d = $urandom % 6;
            case ($urandom % 5)
                0: w = reg_form(op_add, d, prev, prev2);
                1: w = imm_form(op_add, d, prev, $urandom % 32);
                2: w = reg_form(op_and, d, prev, prev2);
                3: w = imm_form(op_and, d, prev, $urandom % 32);
                default: w = base_form(op_not, d, prev, -1);
            endcase
            put_instr(w);
            prev2 = prev;
            prev = d;
            if (i % 3 == 2)
                put_instr(base_form(op_str, d, 6, i));
        end
        // loads used right away
        for (i = 0; i < 6; i++)
        begin
            put_instr(base_form(op_ldr, 1, 6, i));
            put_instr(imm_form(op_add, 2, 1, i - 4));
            put_instr(base_form(op_ldr, 3, 6, i + 8));
            put_instr(base_form(op_str, 3, 6, i + 16));
            put_instr(base_form(op_str, 2, 6, i + 24));
        end
        // r5 zero, r7 all ones
        put_instr(imm_form(op_and, 5, 5, 0));
        put_instr(base_form(op_not, 7, 5, -1));
        for (i = 0; i < 28; i++)
        begin
            v = (i % 3 == 0) ? -3 : ((i % 3 == 1) ? 0 : 5);
            case (i % 4)
                0: put_instr(imm_form(op_add, 4, 5, v));
                1: put_instr(imm_form(op_and, 4, 7, v));
                2:
                begin
                    put_instr(imm_form(op_add, 4, 5, -v - 1));
                    put_instr(base_form(op_not, 4, 4, -1));
                end
                default:
                begin
                    put_instr(imm_form(op_add, 4, 5, v));
                    put_instr(base_form(op_str, 4, 6, 31));
                    put_instr(base_form(op_ldr, 4, 6, 31));
                end
            endcase
            // skips the store when taken
            put_instr(pc_form(op_br, i % 7 + 1, 1));
            put_instr(base_form(op_str, 4, 6, i % 7 + 24));
        end
        // r3 points five words past the LEA
        put_instr(pc_form(op_lea, 3, 4));
        put_instr(base_form(op_str, 3, 6, 0));
        put_instr(base_form(op_jmp, 0, 3, 0));
        put_instr(base_form(op_str, 5, 6, 1));
        put_instr(base_form(op_str, 7, 6, 2));
        put_instr(base_form(op_str, 3, 6, 3));
        put_instr(pc_form(op_br, 7, -1));
    endtask

    // ISA-level interpreter, returns the instruction count up to the final self-branch
    function automatic int run_reference();
        lc3b_word r [reg_count];
        lc3b_word mem [256];
        lc3b_word pc;
        lc3b_word ir;
        lc3b_word src2;
        lc3b_word addr;
        lc3b_word val;
        logic [2:0] cc;
        int steps;
        mem = dmem;
        foreach (r[k])
            r[k] = 16'h0000;
        pc = start_pc;
        cc = 3'b010;
        steps = 0;
        while (steps < 4000)
        begin
            ir = imem[pc[8:1]];
            pc = pc + 16'd2;
            steps++;
            src2 = ir[5] ? {{11{ir[4]}}, ir[4:0]} : r[ir[2:0]];
            addr = r[ir[8:6]] + {{9{ir[5]}}, ir[5:0], 1'b0};
            val = 16'h0000;
            case (ir[15:12])
                op_add: val = r[ir[8:6]] + src2;
                op_and: val = r[ir[8:6]] & src2;
                op_not: val = ~r[ir[8:6]];
                op_ldr: val = mem[addr[8:1]];
                op_lea: r[ir[11:9]] = pc + {{6{ir[8]}}, ir[8:0], 1'b0};
                op_jmp: pc = r[ir[8:6]];
                op_str:
                begin
                    mem[addr[8:1]] = r[ir[11:9]];
                    exp_addr.push_back(addr);
                    exp_data.push_back(r[ir[11:9]]);
                end
                op_br:
                begin
                    if ((ir[11:9] & cc) != 3'b000)
                    begin
                        if (ir[8:0] == 9'h1ff)
                            return steps;
                        pc = pc + {{6{ir[8]}}, ir[8:0], 1'b0};
                    end
                end
                default:
                begin
                end
            endcase
            if (ir[15:12] inside {op_add, op_and, op_not, op_ldr})
            begin
                r[ir[11:9]] = val;
                cc = val[15] ? 3'b100 : ((val == 16'h0000) ? 3'b010 : 3'b001);
            end
        end
        return steps;
    endfunction

    // both memories answer after 0 to 3 cycles
    always @(negedge clk)
    begin
        i_resp = 1'b0;
        d_resp = 1'b0;
        if (!reset && i_read)
        begin
            if (i_wait == 0)
            begin
                i_resp = 1'b1;
                i_rdata = imem[i_addr[8:1]];
                i_wait = $urandom % 4;
            end
            else
                i_wait--;
        end
        if (!reset && (d_read || d_write))
        begin
            if (d_wait == 0)
            begin
                d_resp = 1'b1;
                if (d_write)
                begin
                    dmem[d_addr[8:1]] = d_wdata;
                    seen_addr.push_back(d_addr);
                    seen_data.push_back(d_wdata);
                end
                else
                    d_rdata = dmem[d_addr[8:1]];
                d_wait = $urandom % 4;
            end
            else
                d_wait--;
        end
    end

    // stores are compared in program order
    always @(posedge clk)
    begin
        while (seen_addr.size() > 0)
        begin
            assert (n_checked < exp_addr.size())
            else
            begin
                errors++;
                $display("[ERROR] %0t: extra store of %h to %h", $time, seen_data[0],
                         seen_addr[0]);
            end
            if (n_checked < exp_addr.size())
            begin
                assert (seen_addr[0] == exp_addr[n_checked]
                        && seen_data[0] == exp_data[n_checked])
                else
                begin
                    errors++;
                    $display("[ERROR] %0t: store %0d wrote %h to %h, expected %h to %h",
                             $time, n_checked, seen_data[0], seen_addr[0],
                             exp_data[n_checked], exp_addr[n_checked]);
                end
            end
            n_checked++;
            seen_addr.delete(0);
            seen_data.delete(0);
        end
    end

    initial
    begin
        void'($urandom(rng_seed));
        reset = 1'b1;
        i_rdata = 16'h0000;
        i_resp = 1'b0;
        d_rdata = 16'h0000;
        d_resp = 1'b0;
        i_wait = $urandom % 4;
        d_wait = $urandom % 4;
        build_program();
        limit = cycles_per_instr * run_reference();
        repeat (2)
            @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        while (n_checked < exp_addr.size() && cycles < limit)
            @(negedge clk);
        // catch stray stores after the last expected one
        repeat (20)
            @(negedge clk);
        if (n_checked < exp_addr.size())
        begin
            errors++;
            $display("timeout: only %0d of %0d expected stores appeared after %0d cycles",
                     n_checked, exp_addr.size(), cycles);
        end
        errors += dut0.checks0.failures;
        $display("stores checked: %0d, errors: %0d", n_checked, errors);
        if (errors == 0)
            $display("Test OK");
        else
            $display("Test FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: lc3b_pipeline.f
hdl/lc3b_pkg.sv
hdl/lc3b_ifaces.sv
hdl/fetch_stage.sv
hdl/decode_stage.sv
hdl/execute_stage.sv
hdl/mem_wb_stage.sv
hdl/hazard_unit.sv
hdl/lc3b_pipeline.sv
bench/lc3b_pipeline_assertions.sv
bench/lc3b_pipeline_tb.sv
